// File: sim.f
source/shapes_pkg.sv
source/display_timing.sv
source/draw_regs.sv
source/rect_fill_render.sv
source/fb_bram.sv
source/fb_scanout.sv
source/palette_clut.sv
source/shapes_top.sv
dv/tb_shapes.sv

// File: dv/tb_shapes.sv
/* directed testbench for shapes_top that draws rectangles through the host port
   and checks busy length and every output sample against a reference buffer */
`default_nettype none
`timescale 1ns/1ns

module tb_shapes;

    localparam int H_ACTIVE = 64;
    localparam int H_TOTAL  = 80;
    localparam int V_ACTIVE = 48;
    localparam int V_TOTAL  = 52;
    localparam int FB_W     = 32;
    localparam int FB_H     = 24;
    localparam int FRAME    = H_TOTAL * V_TOTAL;  // samples per frame

    logic                 clk_sys;
    logic                 reset;
    shapes_pkg::reg_wr_t  host_wr;
    logic                 busy;
    shapes_pkg::pix_out_t pix;

    logic [3:0] ref_fb [FB_W * FB_H];  // expected framebuffer contents
    int         errors;
    int         err_mark;               // errors at start of current test
    int         tests_failed;
    int         busy_count;             // busy samples since last clear
    integer     seed;

    shapes_top #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .FB_WIDTH(FB_W), .FB_HEIGHT(FB_H), .FB_SCALE_LOG2(1)
    ) dut (
        .clk_sys(clk_sys),
        .reset  (reset),
        .host_wr(host_wr),
        .busy   (busy),
        .pix    (pix)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;  // 100 ns period
    end

    always @(negedge clk_sys) begin
        if (busy === 1'b1) busy_count++;  // renderer activity monitor
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // index i -> {i i, ~i ~i, i^5 i^5}
    function automatic logic [23:0] palette_rgb(input logic [3:0] i);
        logic [3:0] inv;
        logic [3:0] bx;
        inv = ~i;
        bx  = i ^ 4'h5;
        return {i, i, inv, inv, bx, bx};
    endfunction

    // pixel count after clipping or 0 when rejected
    function automatic int expected_pixels(input int x0, input int y0, input int x1, input int y1);
        if (x0 > x1 || y0 > y1 || x0 >= FB_W || y0 >= FB_H) return 0;
        return ((x1 > FB_W - 1 ? FB_W - 1 : x1) - x0 + 1)
             * ((y1 > FB_H - 1 ? FB_H - 1 : y1) - y0 + 1);
    endfunction

    task automatic paint_ref(input int x0, input int y0, input int x1, input int y1,
                             input logic [3:0] c);
        for (int y = y0; y <= y1 && y < FB_H; y++) begin
            for (int x = x0; x <= x1 && x < FB_W; x++) ref_fb[y * FB_W + x] = c;
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
        @(negedge clk_sys);
        host_wr.we    = 1'b1;
        host_wr.addr  = addr;
        host_wr.wdata = data;
        @(negedge clk_sys);
        host_wr.we    = 1'b0;  // single cycle strobe
    endtask

    task automatic program_rect(input int x0, input int y0, input int x1, input int y1,
                                input logic [3:0] c);
        write_reg(shapes_pkg::REG_X0, x0);
        write_reg(shapes_pkg::REG_Y0, y0);
        write_reg(shapes_pkg::REG_X1, x1);
        write_reg(shapes_pkg::REG_Y1, y1);
        write_reg(shapes_pkg::REG_CIDX, {4'h0, c});
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (busy !== level) report_failure($sformatf("timeout waiting for busy to go %0d", level));
    endtask

    // program, start, then check busy length against the clipped area
    task automatic draw_rect(input int x0, input int y0, input int x1, input int y1,
                             input logic [3:0] c);
        int n;
        n = expected_pixels(x0, y0, x1, y1);
        program_rect(x0, y0, x1, y1, c);
        busy_count = 0;
        write_reg(shapes_pkg::REG_START, 8'h00);
        if (n > 0) begin
            wait_busy(1'b1, 8);
            wait_busy(1'b0, n + 8);
        end
        repeat (8) @(negedge clk_sys);  // no late or second busy pulse
        assert (busy_count == n) else report_mismatch("busy_cycles", busy_count, n);
        paint_ref(x0, y0, x1, y1, c);
    endtask

    task automatic wait_frame(output bit found);
        int n;
        n = 0;
        found = 1'b0;
        while (!found && n < 2 * FRAME + 20) begin
            @(negedge clk_sys);
            found = (pix.frame === 1'b1);
            n++;
        end
        if (!found) report_failure("timeout waiting for a frame start pulse on pix.frame");
    endtask

    // one full frame against the reference from the frame pulse on
    task automatic check_frame;
        bit          found;
        int          ex;
        int          ey;
        logic        exp_de;
        logic [23:0] exp_rgb;
        wait_frame(found);
        if (!found) return;
        for (int s = 0; s < FRAME; s++) begin
            if (s > 0) @(negedge clk_sys);
            ex      = s % H_TOTAL;
            ey      = s / H_TOTAL;
            exp_de  = (ex < H_ACTIVE) && (ey < V_ACTIVE);
            exp_rgb = exp_de ? palette_rgb(ref_fb[(ey >> 1) * FB_W + (ex >> 1)]) : 24'h0;
            assert (pix.sx == ex) else report_mismatch("pix.sx", pix.sx, ex);
            assert (pix.sy == ey) else report_mismatch("pix.sy", pix.sy, ey);
            assert (pix.de === exp_de) else report_mismatch("pix.de", pix.de, exp_de);
            assert ({pix.r, pix.g, pix.b} === exp_rgb)
                else report_mismatch("pix.rgb", {pix.r, pix.g, pix.b}, exp_rgb);
        end
    endtask

    // frame period and de run lengths
    task automatic check_raster;
        bit found;
        int run_len;
        int runs;
        run_len = 0;
        runs    = 0;
        wait_frame(found);
        if (!found) return;
        for (int s = 0; s < FRAME; s++) begin
            if (s > 0) @(negedge clk_sys);
            if (s > 0) assert (pix.frame === 1'b0) else report_mismatch("pix.frame", pix.frame, 0);
            if (pix.de === 1'b1) begin
                run_len++;
            end else if (run_len > 0) begin  // end of an active stretch
                assert (run_len == H_ACTIVE) else report_mismatch("de_run", run_len, H_ACTIVE);
                runs++;
                run_len = 0;
            end
        end
        assert (runs == V_ACTIVE) else report_mismatch("de_lines", runs, V_ACTIVE);
        @(negedge clk_sys);
        assert (pix.frame === 1'b1) else report_mismatch("pix.frame", pix.frame, 1);
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            $display("test %-18s ok", name);
        end else begin
            $display("test %-18s FAILED with %0d errors", name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    task automatic test_reset_state;
        assert (busy === 1'b0) else report_mismatch("busy", busy, 0);
        assert (pix.de === 1'b0) else report_mismatch("pix.de", pix.de, 0);
        for (int i = 0; i < FB_W * FB_H; i++) ref_fb[i] = 4'h0;
        check_frame();  // blank buffer shows entry 0
        end_test("reset_state");
    endtask

    task automatic test_single_rect;
        integer r;
        r = $random(seed);
        draw_rect(3, 2, 12, 9, r[3:0]);
        check_frame();
        end_test("single_rect");
    endtask

    task automatic test_overlap;
        integer     r;
        logic [3:0] ca;
        logic [3:0] cb;
        r  = $random(seed);
        ca = r[3:0];
        r  = $random(seed);
        cb = (r[3:0] == ca) ? ca + 4'h1 : r[3:0];  // keep the overlap visible
        draw_rect(4, 4, 15, 11, ca);
        draw_rect(10, 8, 20, 18, cb);
        check_frame();
        end_test("overlap");
    endtask

    task automatic test_clipping;
        integer r;
        r = $random(seed);
        draw_rect(25, 18, 40, 30, r[3:0]);  // 7 x 6 after clipping
        check_frame();
        end_test("clipping");
    endtask

    task automatic test_rejected;
        integer     r;
        logic [3:0] ca;
        int         n;
        r  = $random(seed);
        ca = r[3:0];
        draw_rect(10, 5, 4, 9, ca);    // inverted
        draw_rect(33, 0, 35, 3, ca);   // off the right edge
        n = expected_pixels(0, 0, 7, 3);
        program_rect(0, 0, 7, 3, ca);
        busy_count = 0;
        write_reg(shapes_pkg::REG_START, 8'h00);
        wait_busy(1'b1, 8);
        program_rect(20, 20, 30, 22, ~ca);      // reprogram mid fill
        write_reg(shapes_pkg::REG_START, 8'h00);  // must be dropped
        wait_busy(1'b0, n + 8);
        repeat (8) @(negedge clk_sys);
        assert (busy_count == n) else report_mismatch("busy_cycles", busy_count, n);
        paint_ref(0, 0, 7, 3, ca);
        check_frame();
        end_test("rejected");
    endtask

    initial begin
        seed         = 32'hf5497876;
        errors       = 0;
        err_mark     = 0;
        tests_failed = 0;
        busy_count   = 0;
        reset        = 1'b1;
        host_wr      = '0;
        repeat (10) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;
        test_reset_state();
        test_single_rect();
        test_overlap();
        test_clipping();
        test_rejected();
        check_raster();
        end_test("raster_timing");
        $display("tests run 6, failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/shapes_top.sv
/* rectangle renderer with scaled framebuffer display, single clock
   host programs corners, colour and start; pix carries the raster out */
`default_nettype none
`timescale 1ns/1ns

module shapes_top #(
    parameter int H_ACTIVE      = 64,
    parameter int H_TOTAL       = 80,
    parameter int V_ACTIVE      = 48,
    parameter int V_TOTAL       = 52,
    parameter int FB_WIDTH      = 32,  // screen is buffer size << FB_SCALE_LOG2
    parameter int FB_HEIGHT     = 24,
    parameter int FB_SCALE_LOG2 = 1
) (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  shapes_pkg::reg_wr_t  host_wr,
    output logic                 busy,
    output shapes_pkg::pix_out_t pix
);

    // raster position
    shapes_pkg::cord_t sx;
    shapes_pkg::cord_t sy;
    logic              de;
    logic              frame;

    // drawing side
    shapes_pkg::rect_cmd_t cmd;
    logic                  start;
    shapes_pkg::fb_wr_t    fb_wr;

    // display side
    logic [shapes_pkg::FB_ADDRW-1:0] rd_addr;
    shapes_pkg::cidx_t               rd_cidx;
    shapes_pkg::cidx_t               pix_cidx;
    logic                            pix_blank;
    shapes_pkg::pix_out_t            pix_pos;

    display_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_TOTAL (V_TOTAL)
    ) u_timing (
        .clk_sys(clk_sys),
        .reset  (reset),
        .sx     (sx),
        .sy     (sy),
        .de     (de),
        .frame  (frame)
    );

    draw_regs u_regs (
        .clk_sys(clk_sys),
        .reset  (reset),
        .host_wr(host_wr),
        .busy   (busy),
        .cmd    (cmd),
        .start  (start)
    );

    rect_fill_render #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) u_render (
        .clk_sys(clk_sys),
        .reset  (reset),
        .cmd    (cmd),
        .start  (start),
        .fb_wr  (fb_wr),
        .busy   (busy)
    );

    fb_bram #(
        .DEPTH(FB_WIDTH * FB_HEIGHT)
    ) u_fb (
        .clk_sys(clk_sys),
        .fb_wr  (fb_wr),
        .rd_addr(rd_addr),
        .rd_cidx(rd_cidx)
    );

    // scanout plus palette, 3 cycles from sx, sy to pix
    fb_scanout #(
        .H_ACTIVE     (H_ACTIVE),
        .V_ACTIVE     (V_ACTIVE),
        .FB_WIDTH     (FB_WIDTH),
        .FB_HEIGHT    (FB_HEIGHT),
        .FB_SCALE_LOG2(FB_SCALE_LOG2)
    ) u_scanout (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .sx       (sx),
        .sy       (sy),
        .de       (de),
        .frame    (frame),
        .rd_cidx  (rd_cidx),
        .rd_addr  (rd_addr),
        .pix_cidx (pix_cidx),
        .pix_blank(pix_blank),
        .pix_pos  (pix_pos)
    );

    palette_clut u_clut (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .pix_cidx (pix_cidx),
        .pix_blank(pix_blank),
        .pix_pos  (pix_pos),
        .pix      (pix)
    );

endmodule

`default_nettype wire

// File: source/palette_clut.sv
/* fixed 16-entry palette and final display register
   index to 8-bit rgb, blanked samples forced to black */
`default_nettype none
`timescale 1ns/1ns

module palette_clut (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  shapes_pkg::cidx_t    pix_cidx,
    input  logic                 pix_blank,
    input  shapes_pkg::pix_out_t pix_pos,
    output shapes_pkg::pix_out_t pix
);

    logic [23:0] clut [16];  // {r, g, b}, 8 bits each

    // red = i, green = ~i, blue = i ^ 5, each nibble doubled
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            clut[i] = {{2{4'(i)}}, {2{~4'(i)}}, {2{4'(i) ^ 4'h5}}};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pix <= '0;  // de and frame low
        end else begin
            pix.sx    <= pix_pos.sx;
            pix.sy    <= pix_pos.sy;
            pix.de    <= pix_pos.de;
            pix.frame <= pix_pos.frame;
            pix.r     <= pix_blank ? 8'h00 : clut[pix_cidx][23:16];
            pix.g     <= pix_blank ? 8'h00 : clut[pix_cidx][15:8];
            pix.b     <= pix_blank ? 8'h00 : clut[pix_cidx][7:0];
        end
    end

endmodule

`default_nettype wire

// File: source/fb_scanout.sv
/* framebuffer scanout, scales screen position down to a buffer address
   and carries position, enable and blanking alongside the read latency */
`default_nettype none
`timescale 1ns/1ns

module fb_scanout #(
    parameter int H_ACTIVE      = 64,
    parameter int V_ACTIVE      = 48,
    parameter int FB_WIDTH      = 32,
    parameter int FB_HEIGHT     = 24,
    parameter int FB_SCALE_LOG2 = 1   // 1 means each buffer pixel is 2x2
) (
    input  logic                            clk_sys,
    input  logic                            reset,
    input  shapes_pkg::cord_t               sx,
    input  shapes_pkg::cord_t               sy,
    input  logic                            de,
    input  logic                            frame,
    input  shapes_pkg::cidx_t               rd_cidx,   // from memory, one cycle after rd_addr
    output logic [shapes_pkg::FB_ADDRW-1:0] rd_addr,
    output shapes_pkg::cidx_t               pix_cidx,
    output logic                            pix_blank,
    output shapes_pkg::pix_out_t            pix_pos
);

    localparam int AW = shapes_pkg::FB_ADDRW;

    shapes_pkg::cord_t    fx;       // buffer column
    shapes_pkg::cord_t    fy;       // buffer row
    logic                 in_area;
    shapes_pkg::pix_out_t pos_in;   // position sample, colour left zero
    shapes_pkg::pix_out_t pos_s1;
    logic                 blank_s1;

    always_comb begin
        fx = sx >> FB_SCALE_LOG2;
        fy = sy >> FB_SCALE_LOG2;
        // inside the visible screen and inside the buffer
        in_area = (sx < H_ACTIVE) && (sy < V_ACTIVE)
            && (fx < FB_WIDTH) && (fy < FB_HEIGHT);
        pos_in       = '0;
        pos_in.sx    = sx;
        pos_in.sy    = sy;
        pos_in.de    = de;
        pos_in.frame = frame;
    end

    // stage 1, address out to memory
    always_ff @(posedge clk_sys) begin
        if (in_area) begin
            rd_addr <= AW'(fy) * AW'(FB_WIDTH) + AW'(fx);
        end else begin
            rd_addr <= '0;  // keep reads inside the array
        end
    end

    // stages 1 and 2 for the side band, meets rd_cidx
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pos_s1    <= '0;
            blank_s1  <= 1'b1;
            pix_pos   <= '0;
            pix_blank <= 1'b1;
        end else begin
            pos_s1    <= pos_in;
            blank_s1  <= !de || !in_area;  // black outside buffer and in blanking
            pix_pos   <= pos_s1;
            pix_blank <= blank_s1;
        end
    end

    assign pix_cidx = rd_cidx;  // already aligned with stage 2

endmodule

`default_nettype wire

// File: source/fb_bram.sv
/* simple dual-port framebuffer, one write and one registered read port
   cleared to index 0 at start, depth set by the top level */
`default_nettype none
`timescale 1ns/1ns

module fb_bram #(
    parameter int DEPTH = 768  // framebuffer pixels
) (
    input  logic                              clk_sys,
    input  shapes_pkg::fb_wr_t                fb_wr,
    input  logic [shapes_pkg::FB_ADDRW-1:0]   rd_addr,
    output shapes_pkg::cidx_t                 rd_cidx
);

    shapes_pkg::cidx_t mem [DEPTH];

    // blank buffer shows palette entry 0
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (fb_wr.we) begin
            mem[fb_wr.addr] <= fb_wr.cidx;
        end
        rd_cidx <= mem[rd_addr];  // old data on same-address collision
    end

endmodule

`default_nettype wire

// File: source/rect_fill_render.sv
/* filled rectangle engine, one framebuffer write per busy cycle
   clips to the buffer edge on start and walks the area in raster order */
`default_nettype none
`timescale 1ns/1ns

module rect_fill_render #(
    parameter int FB_WIDTH  = 32,  // framebuffer width in pixels
    parameter int FB_HEIGHT = 24   // framebuffer height in pixels
) (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  shapes_pkg::rect_cmd_t cmd,
    input  logic                  start,
    output shapes_pkg::fb_wr_t    fb_wr,
    output logic                  busy
);

    localparam int AW = shapes_pkg::FB_ADDRW;

    shapes_pkg::cord_t x1_clip;   // x1 limited to right edge
    shapes_pkg::cord_t y1_clip;   // y1 limited to bottom edge
    logic              cmd_ok;    // non-empty and starts on screen

    shapes_pkg::cord_t x;         // current pixel
    shapes_pkg::cord_t y;
    shapes_pkg::cord_t x0_q;      // latched left edge for row restart
    shapes_pkg::cord_t x1_q;      // latched clipped corners
    shapes_pkg::cord_t y1_q;
    shapes_pkg::cidx_t cidx_q;
    logic [AW-1:0]     row_base;  // y * FB_WIDTH, kept running

    logic last_col;
    logic last_pix;

    // clip and reject on the live command
    always_comb begin
        if (cmd.x1 > shapes_pkg::cord_t'(FB_WIDTH - 1)) begin
            x1_clip = shapes_pkg::cord_t'(FB_WIDTH - 1);
        end else begin
            x1_clip = cmd.x1;
        end
        if (cmd.y1 > shapes_pkg::cord_t'(FB_HEIGHT - 1)) begin
            y1_clip = shapes_pkg::cord_t'(FB_HEIGHT - 1);
        end else begin
            y1_clip = cmd.y1;
        end
        // inverted or fully off screen gives N = 0
        cmd_ok = (cmd.x0 <= cmd.x1) && (cmd.y0 <= cmd.y1)
            && (cmd.x0 < FB_WIDTH) && (cmd.y0 < FB_HEIGHT);
    end

    always_comb begin
        last_col = (x == x1_q);
        last_pix = last_col && (y == y1_q);
    end

    // busy spans exactly the pixel count
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (!busy) begin
            busy <= start && cmd_ok;  // rises the cycle after start
        end else if (last_pix) begin
            busy <= 1'b0;  // final pixel written this cycle
        end
    end

    // walk x then y
    always_ff @(posedge clk_sys) begin
        if (!busy) begin
            if (start) begin  // latch command, start ignored while busy
                x        <= cmd.x0;
                y        <= cmd.y0;
                x0_q     <= cmd.x0;
                x1_q     <= x1_clip;
                y1_q     <= y1_clip;
                cidx_q   <= cmd.cidx;
                row_base <= AW'(cmd.y0) * AW'(FB_WIDTH);  // only multiply, once per shape
            end
        end else if (last_col) begin
            x        <= x0_q;  // back to left edge
            y        <= y + 1'b1;
            row_base <= row_base + AW'(FB_WIDTH);
        end else begin
            x <= x + 1'b1;
        end
    end

    // write port, one pixel per busy cycle
    always_comb begin
        fb_wr.we   = busy;
        fb_wr.addr = row_base + AW'(x);
        fb_wr.cidx = cidx_q;
    end

endmodule

`default_nettype wire

// File: source/draw_regs.sv
/* host register block for the rectangle command
   stores corners and colour and turns a REG_START write into a start pulse */
`default_nettype none
`timescale 1ns/1ns

module draw_regs (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  shapes_pkg::reg_wr_t   host_wr,
    input  logic                  busy,     // renderer still filling
    output shapes_pkg::rect_cmd_t cmd,
    output logic                  start
);

    // start pulse to the renderer
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= 1'b0;  // default low for a one cycle pulse
            if (host_wr.we && host_wr.addr == shapes_pkg::REG_START) begin
                // dropped while renderer busy or about to go busy
                start <= !busy && !start;
            end
        end
    end

    // rectangle fields
    always_ff @(posedge clk_sys) begin
        if (host_wr.we) begin
            case (host_wr.addr)
                shapes_pkg::REG_X0: begin
                    cmd.x0 <= host_wr.wdata;
                end
                shapes_pkg::REG_Y0: begin
                    cmd.y0 <= host_wr.wdata;
                end
                shapes_pkg::REG_X1: begin
                    cmd.x1 <= host_wr.wdata;  // inclusive right edge
                end
                shapes_pkg::REG_Y1: begin
                    cmd.y1 <= host_wr.wdata;  // inclusive bottom edge
                end
                shapes_pkg::REG_CIDX: begin
                    cmd.cidx <= host_wr.wdata[3:0];  // low nibble only
                end
                default: begin
                    // REG_START and unused addresses hold the fields
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/display_timing.sv
/* raster counters for the reduced display, one pixel per clk_sys
   gives screen position with registered data enable and frame start */
`default_nettype none
`timescale 1ns/1ns

module display_timing #(
    parameter int H_ACTIVE = 64,  // visible pixels per line
    parameter int H_TOTAL  = 80,  // pixels per line incl blanking
    parameter int V_ACTIVE = 48,  // visible lines
    parameter int V_TOTAL  = 52   // lines per frame
) (
    input  logic              clk_sys,
    input  logic              reset,
    output shapes_pkg::cord_t sx,
    output shapes_pkg::cord_t sy,
    output logic              de,
    output logic              frame
);

    shapes_pkg::cord_t sx_next;
    shapes_pkg::cord_t sy_next;

    // next raster position
    always_comb begin
        sx_next = sx + 1'b1;
        sy_next = sy;
        if (sx == shapes_pkg::cord_t'(H_TOTAL - 1)) begin  // end of line
            sx_next = '0;
            if (sy == shapes_pkg::cord_t'(V_TOTAL - 1)) begin
                sy_next = '0;  // wrap to top of frame
            end else begin
                sy_next = sy + 1'b1;
            end
        end
    end

    // de and frame decoded from next position so they line up with sx, sy
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            // park on last blanking pixel, 0,0 comes next
            sx    <= shapes_pkg::cord_t'(H_TOTAL - 1);
            sy    <= shapes_pkg::cord_t'(V_TOTAL - 1);
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            de    <= (sx_next < H_ACTIVE) && (sy_next < V_ACTIVE);
            frame <= (sx_next == '0) && (sy_next == '0);  // one pulse per frame
        end
    end

endmodule

`default_nettype wire

// File: source/shapes_pkg.sv
/* shared types and register map for the rectangle renderer
   pulled in by scoped name from every module of the design */
`default_nettype none

package shapes_pkg;

    // framebuffer address width, fits the default 32x24 buffer
    localparam int FB_ADDRW = 10;

    typedef logic [7:0] cord_t;     // screen or framebuffer coordinate
    typedef logic [3:0] cidx_t;     // colour index, 4 bits per pixel
    typedef logic [2:0] reg_addr_t; // host register address

    // host register map
    localparam reg_addr_t REG_X0    = 3'd0;
    localparam reg_addr_t REG_Y0    = 3'd1;
    localparam reg_addr_t REG_X1    = 3'd2;
    localparam reg_addr_t REG_Y1    = 3'd3;
    localparam reg_addr_t REG_CIDX  = 3'd4;
    localparam reg_addr_t REG_START = 3'd5; // write only, kicks the renderer

    typedef struct packed {
        logic      we;    // single cycle strobe
        reg_addr_t addr;
        logic [7:0] wdata;
    } reg_wr_t;

    // programmed rectangle, corners inclusive
    typedef struct packed {
        cord_t x0;
        cord_t y0;
        cord_t x1;
        cord_t y1;
        cidx_t cidx;
    } rect_cmd_t;

    typedef struct packed {
        logic                we;
        logic [FB_ADDRW-1:0] addr; // y * width + x
        cidx_t               cidx;
    } fb_wr_t;

    // display sample, position travels with its colour
    typedef struct packed {
        cord_t      sx;
        cord_t      sy;
        logic       de;
        logic       frame;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pix_out_t;

endpackage

`default_nettype wire
